// ==== rtl/cpu_pkg.sv ====
/*
 * cpu package: widths, memory sizes, opcode/funct/ALU encodings and the nop word
 */
package cpu_pkg;

    localparam int DATA_W      = 32;
    localparam int REG_ADDR_W  = 5;
    localparam int NUM_REGS    = 32;

    localparam int IMEM_DEPTH  = 64;
    localparam int IMEM_ADDR_W = 6;    // word address
    localparam int DMEM_DEPTH  = 64;
    localparam int DMEM_ADDR_W = 6;    // word address

    localparam logic [DATA_W-1:0] NOP_INSTR = '0;    // sll r0,r0,0 pattern, writes nothing

    // primary opcode, instr[31:26]
    typedef enum logic [5:0] {
        OP_RTYPE = 6'd0,
        OP_J     = 6'd2,
        OP_BEQ   = 6'd4,
        OP_BNE   = 6'd5,
        OP_ADDI  = 6'd8,
        OP_LW    = 6'd35,
        OP_SW    = 6'd43
    } opcode_e;

    // R-type funct field, instr[5:0]
    typedef enum logic [5:0] {
        FN_ADD = 6'd32,
        FN_SUB = 6'd34,
        FN_AND = 6'd36,
        FN_OR  = 6'd37,
        FN_SLT = 6'd42
    } funct_e;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_SLT
    } alu_op_e;

endpackage

// ==== rtl/hazard_ctrl.sv ====
/*
 * hazard control: read-after-write check of decode sources against
 * the execute and memory stage destinations, drives the pipeline stall
 */
`timescale 1ns/10ps

module hazard_ctrl (
    input  logic [cpu_pkg::REG_ADDR_W-1:0] d_rs,
    input  logic [cpu_pkg::REG_ADDR_W-1:0] d_rt,
    input  logic                          d_uses_rs,
    input  logic                          d_uses_rt,
    input  logic                          ex_reg_write,
    input  logic [cpu_pkg::REG_ADDR_W-1:0] ex_dest,
    input  logic                          mem_reg_write,
    input  logic [cpu_pkg::REG_ADDR_W-1:0] mem_dest,
    output logic                          stall
);

    logic ex_hit_rs;
    logic ex_hit_rt;
    logic mem_hit_rs;
    logic mem_hit_rt;

    // reg_write is already low for r0, no zero check needed
    assign ex_hit_rs  = ex_reg_write && (ex_dest == d_rs);
    assign ex_hit_rt  = ex_reg_write && (ex_dest == d_rt);
    assign mem_hit_rs = mem_reg_write && (mem_dest == d_rs);
    assign mem_hit_rt = mem_reg_write && (mem_dest == d_rt);

    // write-back producers are covered by the regfile bypass
    assign stall = (d_uses_rs && (ex_hit_rs || mem_hit_rs)) ||
                   (d_uses_rt && (ex_hit_rt || mem_hit_rt));

endmodule

// ==== rtl/reg_file.sv ====
/*
 * register file: 32 x 32, r0 reads zero, write-through bypass on all read ports
 */
`timescale 1ns/10ps

module reg_file (
    input  logic                           SYS_clk,
    input  logic                           SYS_reset,
    input  logic [cpu_pkg::REG_ADDR_W-1:0]  rd_addr_a,
    input  logic [cpu_pkg::REG_ADDR_W-1:0]  rd_addr_b,
    output logic [cpu_pkg::DATA_W-1:0]      rd_data_a,
    output logic [cpu_pkg::DATA_W-1:0]      rd_data_b,
    input  logic                           wr_en,
    input  logic [cpu_pkg::REG_ADDR_W-1:0]  wr_addr,
    input  logic [cpu_pkg::DATA_W-1:0]      wr_data,
    input  logic [cpu_pkg::REG_ADDR_W-1:0]  dbg_addr,
    output logic [cpu_pkg::DATA_W-1:0]      dbg_data
);

    logic [cpu_pkg::DATA_W-1:0] regs [cpu_pkg::NUM_REGS];

    function automatic logic [cpu_pkg::DATA_W-1:0] read_reg(
        input logic [cpu_pkg::REG_ADDR_W-1:0] addr
    );
        if (addr == '0)
            return '0;
        if (wr_en && (addr == wr_addr))
            return wr_data;    // same-cycle write-back
        return regs[addr];
    endfunction

    always_ff @(posedge SYS_clk)
    begin
        if (SYS_reset)
        begin
            for (int i = 0; i < cpu_pkg::NUM_REGS; i++)
                regs[i] <= '0;
        end
        else if (wr_en && (wr_addr != '0))
            regs[wr_addr] <= wr_data;
    end

    always_comb
    begin
        rd_data_a = read_reg(rd_addr_a);
        rd_data_b = read_reg(rd_addr_b);
        dbg_data  = read_reg(dbg_addr);
    end

endmodule

// ==== rtl/fetch_unit.sv ====
/*
 * fetch unit: program counter, instruction memory with a load port,
 * next-PC select between redirect, hold and PC+4
 */
`timescale 1ns/10ps

module fetch_unit (
    input  logic                           SYS_clk,
    input  logic                           SYS_reset,
    input  logic                           imem_we,
    input  logic [cpu_pkg::IMEM_ADDR_W-1:0] imem_addr,
    input  logic [cpu_pkg::DATA_W-1:0]      imem_wdata,
    input  logic                           stall,
    input  logic                           d_redirect,
    input  logic [cpu_pkg::DATA_W-1:0]      d_target,
    output logic [cpu_pkg::DATA_W-1:0]      f_instr,
    output logic [cpu_pkg::DATA_W-1:0]      f_pc_plus4
);

    logic [cpu_pkg::DATA_W-1:0] pc;
    logic [cpu_pkg::DATA_W-1:0] imem [cpu_pkg::IMEM_DEPTH];

    initial
    begin
        for (int i = 0; i < cpu_pkg::IMEM_DEPTH; i++)
            imem[i] = '0;    // unloaded words read as nops
    end

    always @(posedge SYS_clk)
    begin
        if (imem_we)
            imem[imem_addr] <= imem_wdata;
    end

    assign f_instr    = imem[pc[cpu_pkg::IMEM_ADDR_W+1:2]];    // async read, word index
    assign f_pc_plus4 = pc + 32'd4;

    always_ff @(posedge SYS_clk)
    begin
        if (SYS_reset)
            pc <= '0;
        else if (d_redirect)    // already qualified by !stall in decode
            pc <= d_target;
        else if (!stall)
            pc <= f_pc_plus4;
    end

endmodule

// ==== rtl/decode_stage.sv ====
/*
 * decode stage: fetch/decode register, instruction decode, sign extension
 * and early branch/jump resolution against the register file
 */
`timescale 1ns/10ps

module decode_stage (
    input  logic                           SYS_clk,
    input  logic                           SYS_reset,
    input  logic                           stall,
    input  logic [cpu_pkg::DATA_W-1:0]      f_instr,
    input  logic [cpu_pkg::DATA_W-1:0]      f_pc_plus4,
    input  logic                           wb_we,
    input  logic [cpu_pkg::REG_ADDR_W-1:0]  wb_dest,
    input  logic [cpu_pkg::DATA_W-1:0]      wb_data,
    input  logic [cpu_pkg::REG_ADDR_W-1:0]  dbg_addr,
    output logic [cpu_pkg::DATA_W-1:0]      dbg_data,
    output logic                           d_redirect,
    output logic [cpu_pkg::DATA_W-1:0]      d_target,
    output logic [cpu_pkg::REG_ADDR_W-1:0]  d_rs,
    output logic [cpu_pkg::REG_ADDR_W-1:0]  d_rt,
    output logic                           d_uses_rs,
    output logic                           d_uses_rt,
    output cpu_pkg::alu_op_e               d_alu_op,
    output logic                           d_alu_src_imm,
    output logic                           d_mem_read,
    output logic                           d_mem_write,
    output logic                           d_reg_write,
    output logic [cpu_pkg::REG_ADDR_W-1:0]  d_dest,
    output logic [cpu_pkg::DATA_W-1:0]      d_rs_val,
    output logic [cpu_pkg::DATA_W-1:0]      d_rt_val,
    output logic [cpu_pkg::DATA_W-1:0]      d_imm
);

    logic [cpu_pkg::DATA_W-1:0] fd_instr;
    logic [cpu_pkg::DATA_W-1:0] fd_pc_plus4;
    cpu_pkg::opcode_e          opcode;
    cpu_pkg::funct_e           funct;
    logic                      wr_op;    // opcode writes a register
    logic                      br_taken;
    logic                      is_jump;

    always_ff @(posedge SYS_clk)
    begin
        if (SYS_reset || d_redirect)
            fd_instr <= cpu_pkg::NOP_INSTR;    // squash the slot behind a taken branch
        else if (!stall)
            fd_instr <= f_instr;
    end

    always_ff @(posedge SYS_clk)
    begin
        if (!stall)
            fd_pc_plus4 <= f_pc_plus4;
    end

    assign opcode = cpu_pkg::opcode_e'(fd_instr[31:26]);
    assign funct  = cpu_pkg::funct_e'(fd_instr[5:0]);
    assign d_rs   = fd_instr[25:21];
    assign d_rt   = fd_instr[20:16];
    assign d_imm  = {{16{fd_instr[15]}}, fd_instr[15:0]};

    always_comb
    begin
        d_alu_op      = cpu_pkg::ALU_ADD;
        d_alu_src_imm = 1'b0;
        d_mem_read    = 1'b0;
        d_mem_write   = 1'b0;
        d_uses_rs     = 1'b0;
        d_uses_rt     = 1'b0;
        wr_op         = 1'b0;
        case (opcode)
            cpu_pkg::OP_RTYPE:
            begin
                d_uses_rs = 1'b1;
                d_uses_rt = 1'b1;
                wr_op     = 1'b1;
                case (funct)
                    cpu_pkg::FN_ADD: d_alu_op = cpu_pkg::ALU_ADD;
                    cpu_pkg::FN_SUB: d_alu_op = cpu_pkg::ALU_SUB;
                    cpu_pkg::FN_AND: d_alu_op = cpu_pkg::ALU_AND;
                    cpu_pkg::FN_OR:  d_alu_op = cpu_pkg::ALU_OR;
                    cpu_pkg::FN_SLT: d_alu_op = cpu_pkg::ALU_SLT;
                    default:         wr_op    = 1'b0;    // unknown funct does nothing
                endcase
            end
            cpu_pkg::OP_ADDI:
            begin
                d_uses_rs     = 1'b1;
                d_alu_src_imm = 1'b1;
                wr_op         = 1'b1;
            end
            cpu_pkg::OP_LW:
            begin
                d_uses_rs     = 1'b1;
                d_alu_src_imm = 1'b1;
                d_mem_read    = 1'b1;
                wr_op         = 1'b1;
            end
            cpu_pkg::OP_SW:
            begin
                d_uses_rs     = 1'b1;
                d_uses_rt     = 1'b1;
                d_alu_src_imm = 1'b1;
                d_mem_write   = 1'b1;
            end
            cpu_pkg::OP_BEQ, cpu_pkg::OP_BNE:
            begin
                d_uses_rs = 1'b1;
                d_uses_rt = 1'b1;
            end
            default:
            begin
                wr_op = 1'b0;    // j and unknown opcodes
            end
        endcase
    end

    assign d_dest      = (opcode == cpu_pkg::OP_RTYPE) ? fd_instr[15:11] : fd_instr[20:16];
    assign d_reg_write = wr_op && (d_dest != '0);    // r0 writes dropped here

    // branch compare in decode, sources already stall-protected
    assign br_taken = ((opcode == cpu_pkg::OP_BEQ) && (d_rs_val == d_rt_val)) ||
                      ((opcode == cpu_pkg::OP_BNE) && (d_rs_val != d_rt_val));
    assign is_jump  = (opcode == cpu_pkg::OP_J);

    assign d_redirect = !stall && (br_taken || is_jump);
    assign d_target   = is_jump ? {fd_pc_plus4[31:28], fd_instr[25:0], 2'b00}
                                : fd_pc_plus4 + {d_imm[29:0], 2'b00};

    reg_file u_regs (
        .SYS_clk   (SYS_clk),
        .SYS_reset (SYS_reset),
        .rd_addr_a (d_rs),
        .rd_addr_b (d_rt),
        .rd_data_a (d_rs_val),
        .rd_data_b (d_rt_val),
        .wr_en     (wb_we),
        .wr_addr   (wb_dest),
        .wr_data   (wb_data),
        .dbg_addr  (dbg_addr),
        .dbg_data  (dbg_data)
    );

endmodule

// ==== rtl/execute_stage.sv ====
/*
 * execute stage: decode/execute register with bubble on stall, operand-B select, ALU
 */
`timescale 1ns/10ps

module execute_stage (
    input  logic                           SYS_clk,
    input  logic                           SYS_reset,
    input  logic                           stall,
    input  cpu_pkg::alu_op_e               d_alu_op,
    input  logic                           d_alu_src_imm,
    input  logic                           d_mem_read,
    input  logic                           d_mem_write,
    input  logic                           d_reg_write,
    input  logic [cpu_pkg::REG_ADDR_W-1:0]  d_dest,
    input  logic [cpu_pkg::DATA_W-1:0]      d_rs_val,
    input  logic [cpu_pkg::DATA_W-1:0]      d_rt_val,
    input  logic [cpu_pkg::DATA_W-1:0]      d_imm,
    output logic [cpu_pkg::DATA_W-1:0]      ex_alu_result,
    output logic [cpu_pkg::DATA_W-1:0]      ex_store_data,
    output logic                           ex_mem_read,
    output logic                           ex_mem_write,
    output logic                           ex_reg_write,
    output logic [cpu_pkg::REG_ADDR_W-1:0]  ex_dest
);

    cpu_pkg::alu_op_e          ex_alu_op;
    logic                      ex_src_imm;
    logic [cpu_pkg::DATA_W-1:0] ex_rs_val;
    logic [cpu_pkg::DATA_W-1:0] ex_imm;
    logic [cpu_pkg::DATA_W-1:0] op_b;

    always_ff @(posedge SYS_clk)
    begin
        if (SYS_reset || stall)    // bubble
        begin
            ex_mem_read  <= 1'b0;
            ex_mem_write <= 1'b0;
            ex_reg_write <= 1'b0;
            ex_dest      <= '0;
        end
        else
        begin
            ex_mem_read  <= d_mem_read;
            ex_mem_write <= d_mem_write;
            ex_reg_write <= d_reg_write;
            ex_dest      <= d_dest;
        end
    end

    always_ff @(posedge SYS_clk)
    begin
        ex_alu_op     <= d_alu_op;
        ex_src_imm    <= d_alu_src_imm;
        ex_rs_val     <= d_rs_val;
        ex_store_data <= d_rt_val;
        ex_imm        <= d_imm;
    end

    assign op_b = ex_src_imm ? ex_imm : ex_store_data;

    always_comb
    begin
        case (ex_alu_op)
            cpu_pkg::ALU_ADD: ex_alu_result = ex_rs_val + op_b;
            cpu_pkg::ALU_SUB: ex_alu_result = ex_rs_val - op_b;
            cpu_pkg::ALU_AND: ex_alu_result = ex_rs_val & op_b;
            cpu_pkg::ALU_OR:  ex_alu_result = ex_rs_val | op_b;
            cpu_pkg::ALU_SLT: ex_alu_result = {31'd0, $signed(ex_rs_val) < $signed(op_b)};
            default:          ex_alu_result = '0;
        endcase
    end

endmodule

// ==== rtl/memory_stage.sv ====
/*
 * memory stage: execute/memory register, data memory with async read,
 * write-back select into the memory/write-back register
 */
`timescale 1ns/10ps

module memory_stage (
    input  logic                           SYS_clk,
    input  logic                           SYS_reset,
    input  logic [cpu_pkg::DATA_W-1:0]      ex_alu_result,
    input  logic [cpu_pkg::DATA_W-1:0]      ex_store_data,
    input  logic                           ex_mem_read,
    input  logic                           ex_mem_write,
    input  logic                           ex_reg_write,
    input  logic [cpu_pkg::REG_ADDR_W-1:0]  ex_dest,
    output logic                           mem_reg_write,
    output logic [cpu_pkg::REG_ADDR_W-1:0]  mem_dest,
    output logic                           wb_we,
    output logic [cpu_pkg::REG_ADDR_W-1:0]  wb_dest,
    output logic [cpu_pkg::DATA_W-1:0]      wb_data
);

    logic                           mem_rd_en;
    logic                           mem_wr_en;
    logic [cpu_pkg::DATA_W-1:0]      mem_addr;    // ALU result, address or value
    logic [cpu_pkg::DATA_W-1:0]      mem_wdata;
    logic [cpu_pkg::DATA_W-1:0]      dmem [cpu_pkg::DMEM_DEPTH];
    logic [cpu_pkg::DMEM_ADDR_W-1:0] dmem_idx;
    logic [cpu_pkg::DATA_W-1:0]      load_data;

    always_ff @(posedge SYS_clk)
    begin
        if (SYS_reset)
        begin
            mem_rd_en     <= 1'b0;
            mem_wr_en     <= 1'b0;
            mem_reg_write <= 1'b0;
            mem_dest      <= '0;
        end
        else
        begin
            mem_rd_en     <= ex_mem_read;
            mem_wr_en     <= ex_mem_write;
            mem_reg_write <= ex_reg_write;
            mem_dest      <= ex_dest;
        end
    end

    always_ff @(posedge SYS_clk)
    begin
        mem_addr  <= ex_alu_result;
        mem_wdata <= ex_store_data;
    end

    assign dmem_idx  = mem_addr[cpu_pkg::DMEM_ADDR_W+1:2];    // word aligned
    assign load_data = dmem[dmem_idx];

    always_ff @(posedge SYS_clk)
    begin
        if (SYS_reset)
        begin
            for (int i = 0; i < cpu_pkg::DMEM_DEPTH; i++)
                dmem[i] <= '0;
        end
        else if (mem_wr_en)
            dmem[dmem_idx] <= mem_wdata;
    end

    always_ff @(posedge SYS_clk)
    begin
        if (SYS_reset)
        begin
            wb_we   <= 1'b0;
            wb_dest <= '0;
        end
        else
        begin
            wb_we   <= mem_reg_write;
            wb_dest <= mem_dest;
        end
    end

    always_ff @(posedge SYS_clk)
    begin
        wb_data <= mem_rd_en ? load_data : mem_addr;    // select ahead of the register
    end

endmodule

// ==== rtl/cpu_top.sv ====
/*
 * cpu top: five-stage pipeline, fetch / decode / execute / memory / write-back,
 * with the hazard stall control and the external load and debug ports
 */
`timescale 1ns/10ps

module cpu_top (
    input  logic                           SYS_clk,
    input  logic                           SYS_reset,
    input  logic                           imem_we,
    input  logic [cpu_pkg::IMEM_ADDR_W-1:0] imem_addr,
    input  logic [cpu_pkg::DATA_W-1:0]      imem_wdata,
    input  logic [cpu_pkg::REG_ADDR_W-1:0]  dbg_addr,
    output logic [cpu_pkg::DATA_W-1:0]      dbg_data
);

    logic                          stall;

    logic [cpu_pkg::DATA_W-1:0]     f_instr;
    logic [cpu_pkg::DATA_W-1:0]     f_pc_plus4;

    logic                          d_redirect;
    logic [cpu_pkg::DATA_W-1:0]     d_target;
    logic [cpu_pkg::REG_ADDR_W-1:0] d_rs;
    logic [cpu_pkg::REG_ADDR_W-1:0] d_rt;
    logic                          d_uses_rs;
    logic                          d_uses_rt;
    cpu_pkg::alu_op_e              d_alu_op;
    logic                          d_alu_src_imm;
    logic                          d_mem_read;
    logic                          d_mem_write;
    logic                          d_reg_write;
    logic [cpu_pkg::REG_ADDR_W-1:0] d_dest;
    logic [cpu_pkg::DATA_W-1:0]     d_rs_val;
    logic [cpu_pkg::DATA_W-1:0]     d_rt_val;
    logic [cpu_pkg::DATA_W-1:0]     d_imm;

    logic [cpu_pkg::DATA_W-1:0]     ex_alu_result;
    logic [cpu_pkg::DATA_W-1:0]     ex_store_data;
    logic                          ex_mem_read;
    logic                          ex_mem_write;
    logic                          ex_reg_write;
    logic [cpu_pkg::REG_ADDR_W-1:0] ex_dest;

    logic                          mem_reg_write;
    logic [cpu_pkg::REG_ADDR_W-1:0] mem_dest;

    logic                          wb_we;
    logic [cpu_pkg::REG_ADDR_W-1:0] wb_dest;
    logic [cpu_pkg::DATA_W-1:0]     wb_data;

    fetch_unit u_fetch (
        .SYS_clk    (SYS_clk),
        .SYS_reset  (SYS_reset),
        .imem_we    (imem_we),
        .imem_addr  (imem_addr),
        .imem_wdata (imem_wdata),
        .stall      (stall),
        .d_redirect (d_redirect),
        .d_target   (d_target),
        .f_instr    (f_instr),
        .f_pc_plus4 (f_pc_plus4)
    );

    decode_stage u_decode (
        .SYS_clk       (SYS_clk),
        .SYS_reset     (SYS_reset),
        .stall         (stall),
        .f_instr       (f_instr),
        .f_pc_plus4    (f_pc_plus4),
        .wb_we         (wb_we),
        .wb_dest       (wb_dest),
        .wb_data       (wb_data),
        .dbg_addr      (dbg_addr),
        .dbg_data      (dbg_data),
        .d_redirect    (d_redirect),
        .d_target      (d_target),
        .d_rs          (d_rs),
        .d_rt          (d_rt),
        .d_uses_rs     (d_uses_rs),
        .d_uses_rt     (d_uses_rt),
        .d_alu_op      (d_alu_op),
        .d_alu_src_imm (d_alu_src_imm),
        .d_mem_read    (d_mem_read),
        .d_mem_write   (d_mem_write),
        .d_reg_write   (d_reg_write),
        .d_dest        (d_dest),
        .d_rs_val      (d_rs_val),
        .d_rt_val      (d_rt_val),
        .d_imm         (d_imm)
    );

    execute_stage u_execute (
        .SYS_clk       (SYS_clk),
        .SYS_reset     (SYS_reset),
        .stall         (stall),
        .d_alu_op      (d_alu_op),
        .d_alu_src_imm (d_alu_src_imm),
        .d_mem_read    (d_mem_read),
        .d_mem_write   (d_mem_write),
        .d_reg_write   (d_reg_write),
        .d_dest        (d_dest),
        .d_rs_val      (d_rs_val),
        .d_rt_val      (d_rt_val),
        .d_imm         (d_imm),
        .ex_alu_result (ex_alu_result),
        .ex_store_data (ex_store_data),
        .ex_mem_read   (ex_mem_read),
        .ex_mem_write  (ex_mem_write),
        .ex_reg_write  (ex_reg_write),
        .ex_dest       (ex_dest)
    );

    memory_stage u_memory (
        .SYS_clk       (SYS_clk),
        .SYS_reset     (SYS_reset),
        .ex_alu_result (ex_alu_result),
        .ex_store_data (ex_store_data),
        .ex_mem_read   (ex_mem_read),
        .ex_mem_write  (ex_mem_write),
        .ex_reg_write  (ex_reg_write),
        .ex_dest       (ex_dest),
        .mem_reg_write (mem_reg_write),
        .mem_dest      (mem_dest),
        .wb_we         (wb_we),
        .wb_dest       (wb_dest),
        .wb_data       (wb_data)
    );

    hazard_ctrl u_hazard (
        .d_rs          (d_rs),
        .d_rt          (d_rt),
        .d_uses_rs     (d_uses_rs),
        .d_uses_rt     (d_uses_rt),
        .ex_reg_write  (ex_reg_write),
        .ex_dest       (ex_dest),
        .mem_reg_write (mem_reg_write),
        .mem_dest      (mem_dest),
        .stall         (stall)
    );

endmodule

// ==== dv/tb_ref_model.svh ====
/*
 * instruction encoders and the architectural reference model,
 * runs prog_mem one instruction at a time into ref_regs
 */
`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

function automatic logic [31:0] enc_r(cpu_pkg::funct_e fn, int rd, int rs, int rt);
    return {cpu_pkg::OP_RTYPE, rs[4:0], rt[4:0], rd[4:0], 5'd0, fn};
endfunction

function automatic logic [31:0] enc_i(cpu_pkg::opcode_e op, int rt, int rs, int imm);
    return {op, rs[4:0], rt[4:0], imm[15:0]};
endfunction

function automatic logic [31:0] enc_j(int idx);
    return {cpu_pkg::OP_J, idx[25:0]};    // word index of the target
endfunction

function automatic void run_reference();
    logic [31:0] regs [32];
    logic [31:0] dmem [64];
    logic [31:0] pc;
    logic [31:0] pc4;
    logic [31:0] instr;
    logic [31:0] imm;
    logic [31:0] addr;
    logic [31:0] a;
    logic [31:0] b;
    logic [4:0]  rd;
    int          steps;
    bit          halted;
    for (int i = 0; i < 32; i++)
        regs[i] = '0;
    for (int i = 0; i < 64; i++)
        dmem[i] = '0;
    pc     = '0;
    steps  = 0;
    halted = 1'b0;
    while (!halted && (pc[31:2] < prog_len) && (steps < REF_MAX_STEPS))
    begin
        instr = prog_mem[pc[7:2]];
        imm   = {{16{instr[15]}}, instr[15:0]};
        a     = regs[instr[25:21]];
        b     = regs[instr[20:16]];
        rd    = instr[15:11];
        pc4   = pc + 32'd4;
        addr  = a + imm;
        pc    = pc4;
        case (instr[31:26])
            cpu_pkg::OP_RTYPE:
            begin
                case (instr[5:0])
                    cpu_pkg::FN_ADD: regs[rd] = a + b;
                    cpu_pkg::FN_SUB: regs[rd] = a - b;
                    cpu_pkg::FN_AND: regs[rd] = a & b;
                    cpu_pkg::FN_OR:  regs[rd] = a | b;
                    cpu_pkg::FN_SLT: regs[rd] = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                    default:         regs[0]  = '0;    // other funct writes nothing
                endcase
            end
            cpu_pkg::OP_ADDI: regs[instr[20:16]] = addr;
            cpu_pkg::OP_LW:   regs[instr[20:16]] = dmem[addr[7:2]];
            cpu_pkg::OP_SW:   dmem[addr[7:2]]   = b;
            cpu_pkg::OP_BEQ:  if (a == b) pc = pc4 + {imm[29:0], 2'b00};
            cpu_pkg::OP_BNE:  if (a != b) pc = pc4 + {imm[29:0], 2'b00};
            cpu_pkg::OP_J:
            begin
                pc     = {pc4[31:28], instr[25:0], 2'b00};
                halted = (pc == pc4 - 32'd4);    // jump to itself ends the program
            end
            default:          regs[0] = '0;
        endcase
        regs[0] = '0;
        steps++;
    end
    for (int i = 0; i < 32; i++)
        ref_regs[i] = regs[i];
endfunction

`endif

// ==== dv/tb_cpu.sv ====
/*
 * testbench for the five-stage cpu that loads programs during reset, lets them run
 * and checks the register file against the reference model
 */
`timescale 1ns/10ps

module tb_cpu;

    localparam int CLK_PERIOD    = 8;
    localparam int RESET_CYCLES  = 8;
    localparam int NUM_RANDOM    = 20;
    localparam int NUM_PROGS     = 6 + NUM_RANDOM;
    localparam int REF_MAX_STEPS = 1000;
    localparam int PROG_BUDGET   = 5 * cpu_pkg::IMEM_DEPTH + 20 + 2 * cpu_pkg::NUM_REGS + 8;
    localparam int WDOG_CYCLES   = NUM_PROGS * PROG_BUDGET + 200;

    logic        SYS_clk;
    logic        SYS_reset;
    logic        imem_we;
    logic [5:0]  imem_addr;
    logic [31:0] imem_wdata;
    logic [4:0]  dbg_addr;
    logic [31:0] dbg_data;

    logic [31:0] prog_mem [64];
    int          prog_len;
    logic [31:0] ref_regs [32];
    logic [31:0] dut_regs [32];
    string       prog_name;
    event        regs_ready;
    int          errors;
    int          checks;
    int          progs_run;
    int          progs_checked;

    `include "tb_ref_model.svh"

    cpu_top dut (
        .SYS_clk    (SYS_clk),
        .SYS_reset  (SYS_reset),
        .imem_we    (imem_we),
        .imem_addr  (imem_addr),
        .imem_wdata (imem_wdata),
        .dbg_addr   (dbg_addr),
        .dbg_data   (dbg_data)
    );

    always #(CLK_PERIOD / 2) SYS_clk = ~SYS_clk;

    task automatic emit(input logic [31:0] word);
        prog_mem[prog_len] = word;
        prog_len++;
    endtask

    task automatic emit_halt();
        emit(enc_j(prog_len));    // j to itself
    endtask

    // load one word per cycle while the core is held in reset
    task automatic load_and_reset();
        int cycles;
        cycles = (prog_len > RESET_CYCLES) ? prog_len : RESET_CYCLES;
        @(negedge SYS_clk);
        SYS_reset = 1'b1;
        for (int i = 0; i < cycles; i++)
        begin
            imem_we    = (i < prog_len);
            imem_addr  = 6'(i);
            imem_wdata = (i < prog_len) ? prog_mem[i] : '0;
            @(negedge SYS_clk);
        end
        imem_we   = 1'b0;
        SYS_reset = 1'b0;
    endtask

    task automatic run_program(input string name);
        prog_name = name;
        run_reference();
        load_and_reset();
        repeat (4 * prog_len + 20) @(negedge SYS_clk);
        for (int r = 0; r < 32; r++)
        begin
            @(negedge SYS_clk);
            dbg_addr = 5'(r);
            @(negedge SYS_clk);
            dut_regs[r] = dbg_data;    // core is parked on its final jump
        end
        progs_run++;
        -> regs_ready;
        wait (progs_checked == progs_run);
    endtask

    task automatic build_random();
        int n;
        int kind;
        int rd;
        int rs;
        int rt;
        int imm;
        prog_len = 0;
        n = $urandom_range(30, 12);
        for (int i = 0; i < n; i++)
        begin
            kind = $urandom_range(7, 0);
            rd   = $urandom_range(7, 1);
            rs   = $urandom_range(7, 1);
            rt   = $urandom_range(7, 1);
            imm  = $urandom_range(65535, 0);
            case (kind)
                0:       emit(enc_r(cpu_pkg::FN_ADD, rd, rs, rt));
                1:       emit(enc_r(cpu_pkg::FN_SUB, rd, rs, rt));
                2:       emit(enc_r(cpu_pkg::FN_AND, rd, rs, rt));
                3:       emit(enc_r(cpu_pkg::FN_OR, rd, rs, rt));
                4:       emit(enc_r(cpu_pkg::FN_SLT, rd, rs, rt));
                5:       emit(enc_i(cpu_pkg::OP_ADDI, rd, rs, imm));
                6:       emit(enc_i(cpu_pkg::OP_LW, rd, rs, imm));    // index from address bits [7:2]
                default: emit(enc_i(cpu_pkg::OP_SW, rt, rs, imm));
            endcase
        end
        emit_halt();
    endtask

    always @(regs_ready)
    begin
        for (int r = 0; r < 32; r++)
        begin
            checks++;
            assert (dut_regs[r] === ref_regs[r])
            else
            begin
                errors++;
                $display("** Error @ %0t: %s, r%0d = 0x%08h, expected 0x%08h",
                         $time, prog_name, r, dut_regs[r], ref_regs[r]);
            end
        end
        progs_checked++;
    end

    initial
    begin
        #(CLK_PERIOD * WDOG_CYCLES);
        $display("watchdog expired after %0d cycles, programs did not finish", WDOG_CYCLES);
        $display("Test failures found");
        $finish;
    end

    initial
    begin
        void'($urandom(32'h9dd04409));
        SYS_clk       = 1'b0;
        SYS_reset     = 1'b1;
        imem_we       = 1'b0;
        imem_addr     = '0;
        imem_wdata    = '0;
        dbg_addr      = '0;
        errors        = 0;
        checks        = 0;
        progs_run     = 0;
        progs_checked = 0;

        prog_len = 0;
        run_program("empty program");

        prog_len = 0;
        emit(enc_i(cpu_pkg::OP_ADDI, 0, 0, 5));    // r0 must stay zero
        emit(enc_i(cpu_pkg::OP_ADDI, 1, 0, 7));
        emit_halt();
        run_program("r0 write");

        prog_len = 0;
        emit(enc_i(cpu_pkg::OP_ADDI, 1, 0, 5));
        emit(enc_i(cpu_pkg::OP_ADDI, 2, 1, 3));
        emit(enc_r(cpu_pkg::FN_ADD, 3, 1, 2));
        emit(enc_r(cpu_pkg::FN_SUB, 4, 3, 1));
        emit(enc_r(cpu_pkg::FN_AND, 5, 4, 3));
        emit(enc_r(cpu_pkg::FN_OR, 6, 5, 2));
        emit(enc_r(cpu_pkg::FN_SLT, 7, 4, 3));
        emit(enc_i(cpu_pkg::OP_ADDI, 9, 0, -2));
        emit(enc_i(cpu_pkg::OP_ADDI, 10, 0, 1));
        emit(enc_r(cpu_pkg::FN_ADD, 11, 9, 10));    // r9 in memory and r10 in execute
        emit(enc_r(cpu_pkg::FN_SLT, 12, 9, 10));
        emit(enc_r(cpu_pkg::FN_SLT, 13, 10, 9));
        emit(enc_i(cpu_pkg::OP_ADDI, 14, 0, 16'h7fff));
        emit(enc_i(cpu_pkg::OP_ADDI, 14, 14, 16'h7fff));
        emit(enc_r(cpu_pkg::FN_SUB, 15, 0, 14));
        emit_halt();
        run_program("dependent alu chain");

        prog_len = 0;
        emit(enc_i(cpu_pkg::OP_ADDI, 1, 0, 16'h1234));
        emit(enc_i(cpu_pkg::OP_SW, 1, 0, 8));
        emit(enc_i(cpu_pkg::OP_LW, 2, 0, 8));
        emit(enc_r(cpu_pkg::FN_ADD, 3, 2, 1));    // load feeds the alu
        emit(enc_i(cpu_pkg::OP_ADDI, 4, 0, 16));
        emit(enc_i(cpu_pkg::OP_SW, 3, 4, -4));
        emit(enc_i(cpu_pkg::OP_LW, 5, 0, 12));
        emit(enc_r(cpu_pkg::FN_SUB, 6, 5, 2));
        emit(enc_i(cpu_pkg::OP_SW, 6, 4, 0));
        emit(enc_i(cpu_pkg::OP_LW, 7, 4, 0));
        emit(enc_r(cpu_pkg::FN_OR, 8, 7, 5));
        emit_halt();
        run_program("store and load");

        prog_len = 0;
        emit(enc_i(cpu_pkg::OP_ADDI, 1, 0, 3));
        emit(enc_i(cpu_pkg::OP_ADDI, 2, 0, 3));
        emit(enc_i(cpu_pkg::OP_BEQ, 2, 1, 1));    // taken on fresh r2
        emit(enc_i(cpu_pkg::OP_ADDI, 3, 0, 99));
        emit(enc_i(cpu_pkg::OP_BNE, 2, 1, 1));    // not taken
        emit(enc_i(cpu_pkg::OP_ADDI, 4, 0, 4));
        emit(enc_i(cpu_pkg::OP_ADDI, 5, 1, -1));
        emit(enc_i(cpu_pkg::OP_BNE, 1, 5, 1));
        emit(enc_i(cpu_pkg::OP_ADDI, 6, 0, 66));
        emit(enc_i(cpu_pkg::OP_BEQ, 0, 5, 1));
        emit(enc_i(cpu_pkg::OP_ADDI, 7, 0, 7));
        emit(enc_i(cpu_pkg::OP_ADDI, 10, 0, 2));
        emit(enc_i(cpu_pkg::OP_ADDI, 10, 10, -1));
        emit(enc_i(cpu_pkg::OP_ADDI, 11, 11, 2));
        emit(enc_i(cpu_pkg::OP_BNE, 0, 10, -3));    // backward loop
        emit(enc_i(cpu_pkg::OP_BEQ, 0, 0, 1));
        emit(enc_i(cpu_pkg::OP_ADDI, 12, 0, 1));
        emit_halt();
        run_program("branches");

        prog_len = 0;
        emit(enc_i(cpu_pkg::OP_ADDI, 1, 0, 1));
        emit(enc_j(prog_len + 3));
        emit(enc_i(cpu_pkg::OP_ADDI, 2, 0, 2));
        emit(enc_i(cpu_pkg::OP_ADDI, 3, 0, 3));
        emit(enc_i(cpu_pkg::OP_ADDI, 4, 1, 4));
        emit(enc_j(prog_len + 2));
        emit(enc_i(cpu_pkg::OP_ADDI, 5, 0, 5));
        emit_halt();
        run_program("jumps");

        for (int p = 0; p < NUM_RANDOM; p++)
        begin
            build_random();
            run_program($sformatf("random program %0d", p));
        end

        $display("tb_cpu: %0d errors in %0d register checks over %0d programs",
                 errors, checks, progs_checked);
        if ((errors == 0) && (progs_checked == NUM_PROGS))
            $display("All tests passed!");
        else
            $display("Test failures found");
        $finish;
    end

endmodule

// ==== flist.f ====
+incdir+dv
rtl/cpu_pkg.sv
rtl/hazard_ctrl.sv
rtl/reg_file.sv
rtl/fetch_unit.sv
rtl/decode_stage.sv
rtl/execute_stage.sv
rtl/memory_stage.sv
rtl/cpu_top.sv
dv/tb_cpu.sv

// ==== Makefile ====
# Verilator build and run of the pipelined cpu testbench

VERILATOR ?= verilator
TOP       := tb_cpu
FLIST     := flist.f
OBJ_DIR   := obj_dir
VFLAGS    := --binary --timing --assert -Wno-fatal --Mdir $(OBJ_DIR)
LINTFLAGS := --lint-only --timing -Wall
PASS_MSG  := All tests passed!

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf $(OBJ_DIR)
